/* src/hub_pkg.sv */
// Shared types for the mining hub, referenced with scoped names by every RTL file
package hub_pkg;

  // Nonce value as produced by one hashing slave
  typedef logic [31:0] nonce_t;

  // One UART payload byte
  typedef logic [7:0] byte_t;

  // Slave index, also sent as the first byte of each frame
  typedef logic [7:0] port_id_t;

  // Bit period divisor, one bit lasts divisor + 1 clocks
  typedef logic [15:0] baud_div_t;

  // Accepted result handed from the core to the serializer
  typedef struct packed {
    port_id_t port;
    nonce_t   nonce;
  } nonce_msg_t;

  // Serializer FSM
  //   IDLE  waiting for a send from the core
  //   LOAD  capture the message
  //   SEND  present a byte to the transmitter
  //   WAIT  transmitter busy with the byte
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    LOAD = 2'd1,
    SEND = 2'd2,
    WAIT = 2'd3
  } ser_state_t;

  // Number of bytes in one frame, port byte plus four nonce bytes
  localparam int FRAME_BYTES = 5;

endpackage

/* src/hub_config.sv */
// Host-writable configuration registers for baud divisor and slave enable mask
`timescale 1ns/1ps

module hub_config #(
  parameter int                 SLAVES           = 4,
  parameter hub_pkg::baud_div_t DEFAULT_BAUD_DIV = 16'd7
) (
  input  logic               uart_clk,
  input  logic               rst_n,
  input  logic               cfg_we,
  input  logic               cfg_addr,
  input  logic [15:0]        cfg_wdata,
  output hub_pkg::baud_div_t baud_div,
  output logic [SLAVES-1:0]  slave_mask
);

  // Write data padded so the mask slice is valid for any slave count
  logic [SLAVES+15:0] wdata_ext;

  // Divisor of zero would give a one-cycle bit
  hub_pkg::baud_div_t div_wr;

  assign wdata_ext = {{SLAVES{1'b0}}, cfg_wdata};
  assign div_wr    = (cfg_wdata == 16'd0) ? 16'd1 : cfg_wdata;

  // Divisor register
  always_ff @(posedge uart_clk) begin
    if (!rst_n) begin
      baud_div <= DEFAULT_BAUD_DIV;
    end else if (cfg_we && (cfg_addr == 1'b0)) begin
      baud_div <= div_wr;
    end
  end

  // Enable mask with all slaves on after reset
  always_ff @(posedge uart_clk) begin
    if (!rst_n) begin
      slave_mask <= '1;
    end else if (cfg_we && (cfg_addr == 1'b1)) begin
      slave_mask <= wdata_ext[SLAVES-1:0];
    end
  end

endmodule

/* src/hub_core.sv */
// Round-robin nonce collector that picks pending slave results for the serializer
`timescale 1ns/1ps

module hub_core #(
  parameter int SLAVES = 4
) (
  input  logic                  uart_clk,
  input  logic                  rst_n,
  input  logic [SLAVES-1:0]     new_nonces,
  input  logic [SLAVES*32-1:0]  slave_nonces,
  input  logic [SLAVES-1:0]     slave_mask,
  input  logic                  serial_busy,
  output logic                  serial_send,
  output hub_pkg::nonce_msg_t   golden_msg
);

  localparam int PCW = (SLAVES > 1) ? $clog2(SLAVES) : 1;

  logic [PCW-1:0]    port_counter;
  logic [SLAVES-1:0] pending;
  logic [SLAVES-1:0] arrivals;

  // Latest nonce per slave
  hub_pkg::nonce_t nonce_q [SLAVES];

  // Disabled slaves are ignored
  assign arrivals = new_nonces & slave_mask;

  // Take the slave under the counter when the serial path is free
  assign serial_send = !serial_busy && pending[port_counter];

  // Free-running scan over the slaves
  always_ff @(posedge uart_clk) begin
    if (!rst_n) begin
      port_counter <= '0;
    end else if (port_counter == PCW'(SLAVES - 1)) begin
      port_counter <= '0;
    end else begin
      port_counter <= port_counter + 1'b1;
    end
  end

  // A fresh pulse wins over the clear of a send
  always_ff @(posedge uart_clk) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      for (int i = 0; i < SLAVES; i++) begin
        if (arrivals[i]) begin
          pending[i] <= 1'b1;
        end else if (serial_send && (port_counter == PCW'(i))) begin
          pending[i] <= 1'b0;
        end
      end
    end
  end

  // Repeated nonce overwrites the one not yet sent
  always_ff @(posedge uart_clk) begin
    for (int i = 0; i < SLAVES; i++) begin
      if (arrivals[i]) begin
        nonce_q[i] <= slave_nonces[i*32 +: 32];
      end
    end
  end

  always_ff @(posedge uart_clk) begin
    if (serial_send) begin
      golden_msg.port  <= hub_pkg::port_id_t'(port_counter);
      golden_msg.nonce <= nonce_q[port_counter];
    end
  end

  a_counter_range : assert property (
    @(posedge uart_clk) disable iff (!rst_n)
    port_counter <= PCW'(SLAVES - 1)
  );

  // Serializer answers a send with busy, so no second send follows
  a_send_then_busy : assert property (
    @(posedge uart_clk) disable iff (!rst_n)
    serial_send |=> serial_busy && !serial_send
  );

  a_send_clears : assert property (
    @(posedge uart_clk) disable iff (!rst_n)
    serial_send && !arrivals[port_counter] |=> !pending[$past(port_counter)]
  );

endmodule

/* src/nonce_serializer.sv */
// Splits an accepted nonce message into a five-byte frame for the UART transmitter
`timescale 1ns/1ps

module nonce_serializer (
  input  logic                uart_clk,
  input  logic                rst_n,
  input  logic                serial_send,
  input  hub_pkg::nonce_msg_t golden_msg,
  input  logic                tx_busy,
  output logic                serial_busy,
  output logic                tx_start,
  output hub_pkg::byte_t      tx_data
);

  hub_pkg::ser_state_t state;
  hub_pkg::nonce_msg_t msg_q;

  // 0 is the port byte, 1 to 4 the nonce bytes
  logic [2:0] byte_idx;

  // Start a byte as soon as the transmitter is free
  assign tx_start = (state == hub_pkg::SEND) && !tx_busy;

  always_comb begin
    case (byte_idx)
      3'd0:    tx_data = msg_q.port;
      3'd1:    tx_data = msg_q.nonce[7:0];
      3'd2:    tx_data = msg_q.nonce[15:8];
      3'd3:    tx_data = msg_q.nonce[23:16];
      default: tx_data = msg_q.nonce[31:24];
    endcase
  end

  always_ff @(posedge uart_clk) begin
    if (!rst_n) begin
      state       <= hub_pkg::IDLE;
      serial_busy <= 1'b0;
      byte_idx    <= '0;
    end else begin
      case (state)
        hub_pkg::IDLE: begin
          if (serial_send) begin
            state       <= hub_pkg::LOAD;
            serial_busy <= 1'b1;
          end
        end
        hub_pkg::LOAD: begin
          byte_idx <= '0;
          state    <= hub_pkg::SEND;
        end
        hub_pkg::SEND: begin
          if (tx_start) begin
            state <= hub_pkg::WAIT;
          end
        end
        hub_pkg::WAIT: begin
          // Busy is already up here, wait for the byte to finish
          if (!tx_busy) begin
            if (byte_idx == 3'(hub_pkg::FRAME_BYTES - 1)) begin
              state       <= hub_pkg::IDLE;
              serial_busy <= 1'b0;
            end else begin
              byte_idx <= byte_idx + 1'b1;
              state    <= hub_pkg::SEND;
            end
          end
        end
        default: state <= hub_pkg::IDLE;
      endcase
    end
  end

  // Core message is stable in the cycle after the send
  always_ff @(posedge uart_clk) begin
    if (state == hub_pkg::LOAD) begin
      msg_q <= golden_msg;
    end
  end

  // Start only into an idle transmitter, which must then report busy
  a_start_idle : assert property (
    @(posedge uart_clk) disable iff (!rst_n)
    tx_start |-> !tx_busy ##1 tx_busy
  );

endmodule

/* src/uart_tx.sv */
// 8N1 UART transmitter with a bit period set by the configured divisor
`timescale 1ns/1ps

module uart_tx (
  input  logic               uart_clk,
  input  logic               rst_n,
  input  logic               tx_start,
  input  hub_pkg::byte_t     tx_data,
  input  hub_pkg::baud_div_t baud_div,
  output logic               tx_busy,
  output logic               txd
);

  // Divisor captured per character
  hub_pkg::baud_div_t div_q;
  hub_pkg::baud_div_t period_cnt;

  // Bits still to go out with the stop bit on top
  logic [8:0] shift_q;

  // Number of finished bits in the character
  logic [3:0] bit_cnt;

  always_ff @(posedge uart_clk) begin
    if (!rst_n) begin
      tx_busy    <= 1'b0;
      txd        <= 1'b1;
      bit_cnt    <= '0;
      period_cnt <= '0;
    end else if (!tx_busy) begin
      if (tx_start) begin
        // Start bit goes out right away
        tx_busy    <= 1'b1;
        txd        <= 1'b0;
        bit_cnt    <= '0;
        period_cnt <= baud_div;
      end
    end else if (period_cnt != '0) begin
      period_cnt <= period_cnt - 1'b1;
    end else begin
      period_cnt <= div_q;
      if (bit_cnt == 4'd9) begin
        // Line stays high after the stop bit
        tx_busy <= 1'b0;
        txd     <= 1'b1;
      end else begin
        txd     <= shift_q[0];
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // Data path
  always_ff @(posedge uart_clk) begin
    if (!tx_busy && tx_start) begin
      shift_q <= {1'b1, tx_data};
      div_q   <= baud_div;
    end else if (tx_busy && (period_cnt == '0)) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

endmodule

/* src/mining_hub_top.sv */
// Top level of the mining hub, joining configuration, collector, serializer and UART
`timescale 1ns/1ps

module mining_hub_top #(
  parameter int                 SLAVES           = 4,
  parameter hub_pkg::baud_div_t DEFAULT_BAUD_DIV = 16'd7
) (
  input  logic                 uart_clk,
  input  logic                 rst_n,
  input  logic [SLAVES-1:0]    new_nonces,
  input  logic [SLAVES*32-1:0] slave_nonces,
  input  logic                 cfg_we,
  input  logic                 cfg_addr,
  input  logic [15:0]          cfg_wdata,
  output logic                 txd
);

  hub_pkg::baud_div_t  baud_div;
  logic [SLAVES-1:0]   slave_mask;

  // Core to serializer
  logic                serial_send;
  logic                serial_busy;
  hub_pkg::nonce_msg_t golden_msg;

  // Serializer to transmitter
  logic                tx_start;
  logic                tx_busy;
  hub_pkg::byte_t      tx_data;

  hub_config #(
    .SLAVES           (SLAVES),
    .DEFAULT_BAUD_DIV (DEFAULT_BAUD_DIV)
  ) u_hub_config (
    .uart_clk   (uart_clk),
    .rst_n      (rst_n),
    .cfg_we     (cfg_we),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .baud_div   (baud_div),
    .slave_mask (slave_mask)
  );

  hub_core #(
    .SLAVES (SLAVES)
  ) u_hub_core (
    .uart_clk     (uart_clk),
    .rst_n        (rst_n),
    .new_nonces   (new_nonces),
    .slave_nonces (slave_nonces),
    .slave_mask   (slave_mask),
    .serial_busy  (serial_busy),
    .serial_send  (serial_send),
    .golden_msg   (golden_msg)
  );

  nonce_serializer u_nonce_serializer (
    .uart_clk    (uart_clk),
    .rst_n       (rst_n),
    .serial_send (serial_send),
    .golden_msg  (golden_msg),
    .tx_busy     (tx_busy),
    .serial_busy (serial_busy),
    .tx_start    (tx_start),
    .tx_data     (tx_data)
  );

  uart_tx u_uart_tx (
    .uart_clk (uart_clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .baud_div (baud_div),
    .tx_busy  (tx_busy),
    .txd      (txd)
  );

endmodule

/* test/tb_mining_hub.sv */
// Directed testbench for the mining hub, decoding txd frames and checking them against a scoreboard
`timescale 1ns/1ps

module tb_mining_hub;

  localparam int SLAVES     = 4;
  localparam int WAIT_LIMIT = 3000;
  localparam int QUIET_TIME = 400;

  logic                 uart_clk;
  logic                 rst_n;
  logic [SLAVES-1:0]    new_nonces;
  logic [SLAVES*32-1:0] slave_nonces;
  logic                 cfg_we;
  logic                 cfg_addr;
  logic [15:0]          cfg_wdata;
  logic                 txd;

  integer seed = 90301;

  // Copies of what was last written to the configuration block
  hub_pkg::baud_div_t div_copy;
  int unsigned        bit_len;
  logic [SLAVES-1:0]  mask_copy;

  // Pending nonce per slave, plus the last value driven on each slave
  bit                 exp_pending [SLAVES];
  hub_pkg::nonce_t    exp_nonce [SLAVES];
  hub_pkg::nonce_t    last_nonce [SLAVES];

  mining_hub_top #(
    .SLAVES           (SLAVES),
    .DEFAULT_BAUD_DIV (16'd7)
  ) u_mining_hub_top (
    .uart_clk     (uart_clk),
    .rst_n        (rst_n),
    .new_nonces   (new_nonces),
    .slave_nonces (slave_nonces),
    .cfg_we       (cfg_we),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .txd          (txd)
  );

  initial begin
    uart_clk = 1'b0;
    forever #2 uart_clk = ~uart_clk;
  end

  task automatic abort_sim();
    $display("Something failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("CHECK FAILED at %0t ns: %s expected 0x%08h got 0x%08h",
               $time, name, expected, actual);
      abort_sim();
    end
  endtask

  task automatic write_cfg(input logic addr, input logic [15:0] data);
    @(posedge uart_clk);
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge uart_clk);
    cfg_we <= 1'b0;
    if (addr == 1'b0) begin
      // Zero is stored as one by the hub
      div_copy = (data == 16'd0) ? 16'd1 : data;
      bit_len  = int'(div_copy) + 1;
    end else begin
      mask_copy = data[SLAVES-1:0];
    end
  endtask

  // One-cycle pulse on the selected slaves with fresh random nonces
  task automatic pulse_slaves(input logic [SLAVES-1:0] which);
    logic [SLAVES*32-1:0] values;
    values = slave_nonces;
    for (int i = 0; i < SLAVES; i++) begin
      if (which[i]) begin
        last_nonce[i]      = $random(seed);
        values[i*32 +: 32] = last_nonce[i];
        // Masked slaves never become pending
        if (mask_copy[i]) begin
          exp_pending[i] = 1'b1;
          exp_nonce[i]   = last_nonce[i];
        end
      end
    end
    @(posedge uart_clk);
    new_nonces   <= which;
    slave_nonces <= values;
    @(posedge uart_clk);
    new_nonces <= '0;
  endtask

  // Returns half a clock into the start bit
  task automatic wait_for_start();
    int waited;
    waited = 0;
    @(negedge uart_clk);
    while ((txd !== 1'b0) && (waited < WAIT_LIMIT)) begin
      @(negedge uart_clk);
      waited++;
    end
    if (txd !== 1'b0) begin
      $display("Timeout: no start bit on txd within %0d cycles", WAIT_LIMIT);
      abort_sim();
    end
  endtask

  task automatic recv_byte(output hub_pkg::byte_t data);
    wait_for_start();
    // Middle of the start bit
    repeat (bit_len / 2) @(negedge uart_clk);
    check_value("txd start bit", 32'd0, txd);
    for (int i = 0; i < 8; i++) begin
      repeat (bit_len) @(negedge uart_clk);
      data[i] = txd;
    end
    repeat (bit_len) @(negedge uart_clk);
    check_value("txd stop bit", 32'd1, txd);
  endtask

  task automatic recv_frame(output hub_pkg::nonce_msg_t frame);
    hub_pkg::byte_t b;
    recv_byte(b);
    frame.port = b;
    // Nonce arrives least significant byte first
    for (int i = 0; i < 4; i++) begin
      recv_byte(b);
      frame.nonce[i*8 +: 8] = b;
    end
  endtask

  task automatic score_frame(input hub_pkg::nonce_msg_t frame);
    int idx;
    assert (frame.port < SLAVES) else begin
      $display("CHECK FAILED at %0t ns: frame port expected below %0d got %0d",
               $time, SLAVES, frame.port);
      abort_sim();
    end
    idx = int'(frame.port);
    assert (exp_pending[idx]) else begin
      $display("Frame for slave %0d arrived with no nonce pending for it", idx);
      abort_sim();
    end
    check_value("frame nonce", exp_nonce[idx], frame.nonce);
    exp_pending[idx] = 1'b0;
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge uart_clk);
      assert (txd === 1'b1) else begin
        $display("Unexpected activity on txd at %0t ns while no frame was due", $time);
        abort_sim();
      end
    end
  endtask

  task automatic check_drained();
    for (int i = 0; i < SLAVES; i++) begin
      assert (!exp_pending[i]) else begin
        $display("No frame arrived for the pending nonce of slave %0d", i);
        abort_sim();
      end
    end
  endtask

  task test_single_nonce();
    hub_pkg::nonce_msg_t frame;
    @(negedge uart_clk);
    check_value("txd", 32'd1, txd);
    pulse_slaves(4'b0100);
    recv_frame(frame);
    check_value("frame port", 32'd2, frame.port);
    score_frame(frame);
    expect_quiet(QUIET_TIME);
  endtask

  task test_all_pending();
    hub_pkg::nonce_msg_t frame;
    pulse_slaves(4'b1111);
    // Any order, the scoreboard rejects a repeated index
    repeat (SLAVES) begin
      recv_frame(frame);
      score_frame(frame);
    end
    check_drained();
    expect_quiet(QUIET_TIME);
  endtask

  task test_overwrite();
    hub_pkg::nonce_msg_t first_frame;
    hub_pkg::nonce_msg_t frame;
    hub_pkg::nonce_t     second;
    pulse_slaves(4'b0001);
    fork
      begin
        recv_frame(first_frame);
        check_value("frame port", 32'd0, first_frame.port);
        score_frame(first_frame);
      end
      begin
        // Slave 1 pulses twice while slave 0 is on the line
        wait_for_start();
        pulse_slaves(4'b0010);
        pulse_slaves(4'b0010);
        second = last_nonce[1];
      end
    join
    recv_frame(frame);
    check_value("frame port", 32'd1, frame.port);
    check_value("frame nonce", second, frame.nonce);
    score_frame(frame);
    expect_quiet(QUIET_TIME);
  endtask

  task test_mask();
    hub_pkg::nonce_msg_t frame;
    write_cfg(1'b1, 16'h0007);
    pulse_slaves(4'b1000);
    expect_quiet(QUIET_TIME);
    pulse_slaves(4'b0001);
    recv_frame(frame);
    check_value("frame port", 32'd0, frame.port);
    score_frame(frame);
    expect_quiet(QUIET_TIME);
    write_cfg(1'b1, 16'h000F);
    check_drained();
  endtask

  task test_baud();
    hub_pkg::nonce_msg_t frame;
    write_cfg(1'b0, 16'd3);
    pulse_slaves(4'b0100);
    recv_frame(frame);
    check_value("frame port", 32'd2, frame.port);
    score_frame(frame);
    expect_quiet(QUIET_TIME);
    // Shortest bit, two cycles
    write_cfg(1'b0, 16'd0);
    pulse_slaves(4'b0010);
    recv_frame(frame);
    check_value("frame port", 32'd1, frame.port);
    score_frame(frame);
    expect_quiet(QUIET_TIME);
    write_cfg(1'b0, 16'd7);
    check_drained();
  endtask

  initial begin
    rst_n        <= 1'b0;
    new_nonces   <= '0;
    slave_nonces <= '0;
    cfg_we       <= 1'b0;
    cfg_addr     <= 1'b0;
    cfg_wdata    <= '0;
    div_copy  = 16'd7;
    bit_len   = 8;
    mask_copy = '1;
    for (int i = 0; i < SLAVES; i++) begin
      exp_pending[i] = 1'b0;
      exp_nonce[i]   = '0;
      last_nonce[i]  = '0;
    end
    repeat (3) @(posedge uart_clk);
    rst_n <= 1'b1;

    test_single_nonce();
    test_all_pending();
    test_overwrite();
    test_mask();
    test_baud();

    $display("Everything OK");
    $finish;
  end

endmodule

/* sources.f */
src/hub_pkg.sv
src/hub_config.sv
src/hub_core.sv
src/nonce_serializer.sv
src/uart_tx.sv
src/mining_hub_top.sv
test/tb_mining_hub.sv

/* run_sim.sh */
#!/bin/sh
# Build the mining hub testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
TOP=tb_mining_hub

rm -rf "$OBJ" "$LOG"

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" -Mdir "$OBJ" -f sources.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The testbench prints its pass line only when every check held
if grep -qx "Everything OK" "$LOG"; then
  echo "Simulation result: PASS"
  exit 0
fi

echo "Simulation result: FAIL, pass message not found in $LOG"
exit 1
